/* rtl/serialCore_consts.svh */
`ifndef SERIAL_CORE_CONSTS_SVH
`define SERIAL_CORE_CONSTS_SVH

// byte address bus width
`define CORE_ADDR_WIDTH 16

// first fetch address after reset
`define CORE_RESET_PC 16'h2000

// registers live in memory, four bytes each
`define CORE_REG_COUNT 16

// major opcodes taken from insn[6:2]
`define CORE_OP_LOAD 5'b00000
`define CORE_OP_OPIMM 5'b00100
`define CORE_OP 5'b01100
`define CORE_OP_LUI 5'b01101

`endif

/* rtl/serialCorePkg.sv */
`include "serialCore_consts.svh"

package serialCorePkg;

    // {insn[30], funct3} of the instruction
    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSub = 4'b1000,
        aluXor = 4'b0100,
        aluOr  = 4'b0110,
        aluAnd = 4'b0111
    } aluOpT;

    typedef enum logic [2:0] {
        insnFetch,
        insnFetched,
        regFetch,
        dataFetch,
        regStore
    } coreStateT;

    typedef struct packed {
        logic isLoad;
        logic isLui;
        logic isAluOp;
        // rs1 with immediate when set, rs1 with rs2 otherwise
        logic isAluImmediate;
        aluOpT aluOp;
        logic [$clog2(`CORE_REG_COUNT)-1:0] rs1Idx;
        logic [$clog2(`CORE_REG_COUNT)-1:0] rs2Idx;
        logic [$clog2(`CORE_REG_COUNT)-1:0] rdIdx;
        logic [31:0] immediate;
    } decodedInsnT;

    typedef struct packed {
        logic [`CORE_ADDR_WIDTH-1:0] address;
        logic [7:0] dataWrite;
        logic writeEnable;
        logic strobe;
    } memReqT;

    typedef struct packed {
        logic [7:0] dataRead;
        logic ready;
    } memRespT;

    // per-cycle controls for the X and Y shift registers
    typedef struct packed {
        logic loadX;
        logic loadYFromImm;
        logic loadYFromX;
        logic loadXFromImm;
        logic captureByte;
        logic shiftStart;
        logic stopAtByte;
        logic xFromAlu;
        logic preloadStore;
    } shiftCtrlT;

endpackage

/* rtl/insnDecoder.sv */
`timescale 1ns/100ps
`include "serialCore_consts.svh"

module insnDecoder (
    input  logic [31:0] insn,
    output serialCorePkg::decodedInsnT decoded
);
    import serialCorePkg::*;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic isOpImm;
    logic isOp;
    // only the kept logic and add/sub functions
    logic funct3Legal;
    // register form allows bit 30 for SUB only
    logic funct7Legal;
    logic isValid;

    assign opcode = insn[6:2];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];
    assign isOpImm = opcode == `CORE_OP_OPIMM;
    assign isOp = opcode == `CORE_OP;
    assign funct3Legal = funct3 == 3'b000 || funct3 == 3'b100 ||
                         funct3 == 3'b110 || funct3 == 3'b111;
    assign funct7Legal = funct7 == 7'b0000000 ||
                         (funct7 == 7'b0100000 && funct3 == 3'b000);

    always_comb begin
        decoded = '0;
        // word loads only
        decoded.isLoad = opcode == `CORE_OP_LOAD && funct3 == 3'b010;
        decoded.isLui = opcode == `CORE_OP_LUI;
        decoded.isAluOp = funct3Legal && (isOpImm || (isOp && funct7Legal));
        decoded.isAluImmediate = !insn[5];
        // bit 30 belongs to the immediate in OP-IMM
        decoded.aluOp = aluOpT'({insn[5] & insn[30], funct3});
        decoded.rs1Idx = insn[18:15];
        decoded.rs2Idx = insn[23:20];
        decoded.rdIdx = insn[10:7];

        if (opcode == `CORE_OP_LOAD || isOpImm) begin
            // I-type
            decoded.immediate = {{20{insn[31]}}, insn[31:20]};
        end else if (opcode == `CORE_OP_LUI) begin
            // U-type
            decoded.immediate = {insn[31:12], 12'b0};
        end else begin
            decoded.immediate = '0;
        end
    end

    assign isValid = decoded.isLoad || decoded.isLui || decoded.isAluOp;

    // compressed forms are not fetched, any opcode we act on must be 32-bit
    always_comb begin
        assert #0 ($isunknown(insn) || !isValid || insn[1:0] == 2'b11)
        else $error("decoded a valid opcode with low bits %b", insn[1:0]);
    end

endmodule

/* rtl/serialAlu.sv */
`timescale 1ns/100ps

module serialAlu (
    input  logic cpuSignals,
    input  logic arstN,
    input  serialCorePkg::aluOpT op,
    input  logic clear,
    input  logic xBit,
    input  logic yBit,
    output logic aluBit
);
    import serialCorePkg::*;

    logic carry;
    // subtract as x + ~y + 1
    logic yEff;

    assign yEff = (op == aluSub) ? ~yBit : yBit;

    always_comb begin
        case (op)
            aluAdd, aluSub: aluBit = xBit ^ yEff ^ carry;
            aluXor: aluBit = xBit ^ yBit;
            aluOr: aluBit = xBit | yBit;
            aluAnd: aluBit = xBit & yBit;
            default: aluBit = 1'b0;
        endcase
    end

    always_ff @(posedge cpuSignals or negedge arstN) begin
        if (!arstN) begin
            carry <= 1'b0;
        end else if (clear) begin
            // the +1 of two's complement
            carry <= (op == aluSub);
        end else begin
            carry <= (xBit & yEff) | (xBit & carry) | (yEff & carry);
        end
    end

    // decoder and sequencer together must never hand over a dropped function
    assert property (@(posedge cpuSignals) disable iff (!arstN)
        !clear |-> op inside {aluAdd, aluSub, aluXor, aluOr, aluAnd})
    else $error("illegal ALU op %b", op);

endmodule

/* rtl/operandShifter.sv */
`timescale 1ns/100ps
`include "serialCore_consts.svh"

module operandShifter (
    input  logic cpuSignals,
    input  logic arstN,
    input  serialCorePkg::shiftCtrlT ctrl,
    input  logic [31:0] immediate,
    input  logic [7:0] dataRead,
    input  logic aluBit,
    output logic xBit,
    output logic yBit,
    output logic [7:0] xLowByte,
    output logic [`CORE_ADDR_WIDTH-1:0] xAddr,
    output logic byteDone,
    output logic wordDone
);

    // operand registers, bit 0 goes to the ALU
    logic [31:0] xReg;
    logic [31:0] yReg;
    // bits moved within the current word
    logic [4:0] bitCount;
    // one bit per cycle while set
    logic running;
    // 32 bits passed since the last loadX or preloadStore
    logic wordFlag;
    logic lastBit;
    logic byteBoundary;

    assign lastBit = bitCount == 5'd31;
    assign byteBoundary = bitCount[2:0] == 3'd7;

    always_ff @(posedge cpuSignals or negedge arstN) begin
        if (!arstN) begin
            bitCount <= '0;
            running <= 1'b0;
            wordFlag <= 1'b0;
        end else begin
            if (ctrl.loadX) begin
                bitCount <= '0;
                wordFlag <= 1'b0;
            end else if (ctrl.preloadStore) begin
                // first byte is written as is, 24 bits left to move
                bitCount <= 5'd8;
                wordFlag <= 1'b0;
            end else if (running) begin
                bitCount <= bitCount + 5'd1;
                if (lastBit) begin
                    wordFlag <= 1'b1;
                end
            end

            if (ctrl.shiftStart) begin
                running <= 1'b1;
            end else if (running && (lastBit || (ctrl.stopAtByte && byteBoundary))) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpuSignals) begin
        if (ctrl.loadXFromImm) begin
            xReg <= immediate;
        end else if (ctrl.captureByte) begin
            // byte lands low, 8 shifts later it sits at the top
            xReg[7:0] <= dataRead;
        end else if (running) begin
            xReg <= {ctrl.xFromAlu ? aluBit : xReg[0], xReg[31:1]};
        end

        if (ctrl.loadYFromImm) begin
            yReg <= immediate;
        end else if (ctrl.loadYFromX) begin
            yReg <= xReg;
        end else if (running) begin
            // rotate so y is back in place after a full word
            yReg <= {yReg[0], yReg[31:1]};
        end
    end

    assign xBit = xReg[0];
    assign yBit = yReg[0];
    assign xLowByte = xReg[7:0];
    assign xAddr = xReg[`CORE_ADDR_WIDTH-1:0];
    assign byteDone = !running;
    assign wordDone = wordFlag;

    // sequencer waits for the byte step to end before the next read returns
    assert property (@(posedge cpuSignals) disable iff (!arstN)
        !(ctrl.captureByte && running))
    else $error("byte captured while X is shifting");

endmodule

/* rtl/coreSequencer.sv */
`timescale 1ns/100ps
`include "serialCore_consts.svh"

module coreSequencer (
    input  logic cpuSignals,
    input  logic arstN,
    input  serialCorePkg::memRespT memResp,
    input  serialCorePkg::decodedInsnT decoded,
    input  logic byteDone,
    input  logic wordDone,
    input  logic [7:0] xLowByte,
    input  logic [`CORE_ADDR_WIDTH-1:0] xAddr,
    output serialCorePkg::memReqT memReq,
    output logic [31:0] insn,
    output serialCorePkg::shiftCtrlT ctrl,
    output serialCorePkg::aluOpT aluOp,
    output logic aluClear
);
    import serialCorePkg::*;

    coreStateT state;
    logic [`CORE_ADDR_WIDTH-1:0] pc;
    logic [`CORE_ADDR_WIDTH-1:0] pcNext;
    logic [`CORE_ADDR_WIDTH-1:0] memAddr;
    logic [`CORE_ADDR_WIDTH-1:0] memAddrNext;
    logic [31:0] insnBuf;
    logic strobe;
    logic writeEnable;
    // a byte step or ALU pass was started
    logic shiftWait;
    // X passes through the ALU, no byte stops
    logic aluPass;
    // rs1 fetch of a register-register op
    logic secondOperand;
    logic readDone;
    logic writeDone;
    logic shiftIdle;
    logic rs2First;
    logic wordReady;
    logic startPass;
    logic passDone;

    function automatic logic [`CORE_ADDR_WIDTH-1:0] regAddr(input logic [3:0] idx);
        regAddr = {{(`CORE_ADDR_WIDTH - 6){1'b0}}, idx, 2'b00};
    endfunction

    assign pcNext = pc + 1'b1;
    assign memAddrNext = memAddr + 1'b1;
    assign readDone = strobe && !writeEnable && memResp.ready;
    assign writeDone = strobe && writeEnable && memResp.ready;
    assign shiftIdle = shiftWait && byteDone;
    assign rs2First = decoded.isAluOp && !decoded.isAluImmediate;
    assign wordReady = shiftIdle && !aluPass && wordDone;
    // whole 32-bit pass in one go keeps the carry chain unbroken
    assign startPass = state == regFetch && wordReady && !(rs2First && !secondOperand);
    assign passDone = state == regFetch && shiftIdle && aluPass;

    assign insn = insnBuf;
    assign aluOp = decoded.isAluOp ? decoded.aluOp : aluAdd;
    assign aluClear = startPass;

    always_comb begin
        memReq.address = memAddr;
        memReq.dataWrite = xLowByte;
        memReq.writeEnable = writeEnable;
        memReq.strobe = strobe;
    end

    always_comb begin
        ctrl = '0;
        ctrl.stopAtByte = !aluPass;
        ctrl.xFromAlu = aluPass;
        ctrl.captureByte = readDone && (state == regFetch || state == dataFetch);
        ctrl.shiftStart = ctrl.captureByte || startPass ||
                          (state == regStore && writeDone && !wordDone);
        case (state)
            insnFetched: begin
                if (decoded.isLui) begin
                    ctrl.loadXFromImm = 1'b1;
                    ctrl.preloadStore = 1'b1;
                end else if (decoded.isLoad || (decoded.isAluOp && decoded.isAluImmediate)) begin
                    ctrl.loadYFromImm = 1'b1;
                    ctrl.loadX = 1'b1;
                end else if (decoded.isAluOp) begin
                    ctrl.loadX = 1'b1;
                end
            end
            regFetch: begin
                if (wordReady && rs2First && !secondOperand) begin
                    // rs2 moves over to Y
                    ctrl.loadYFromX = 1'b1;
                    ctrl.loadX = 1'b1;
                end else if (startPass) begin
                    ctrl.loadX = 1'b1;
                end else if (passDone) begin
                    ctrl.loadX = decoded.isLoad;
                    ctrl.preloadStore = !decoded.isLoad;
                end
            end
            dataFetch: begin
                ctrl.preloadStore = wordReady;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge cpuSignals or negedge arstN) begin
        if (!arstN) begin
            state <= insnFetch;
            pc <= `CORE_RESET_PC;
            memAddr <= '0;
            strobe <= 1'b0;
            writeEnable <= 1'b0;
            shiftWait <= 1'b0;
            aluPass <= 1'b0;
            secondOperand <= 1'b0;
            // addi x0, x0, 0
            insnBuf <= 32'h0000_0013;
        end else begin
            if (strobe && memResp.ready) begin
                strobe <= 1'b0;
            end

            if (ctrl.shiftStart) begin
                shiftWait <= 1'b1;
            end else if (shiftIdle) begin
                shiftWait <= 1'b0;
            end

            case (state)
                insnFetch: begin
                    if (readDone) begin
                        // little-endian, slot picked by pc low bits
                        insnBuf[{pc[1:0], 3'b000} +: 8] <= memResp.dataRead;
                        pc <= pcNext;
                        if (pc[1:0] == 2'b11) begin
                            state <= insnFetched;
                        end
                    end else if (!strobe) begin
                        memAddr <= pc;
                        strobe <= 1'b1;
                    end
                end
                insnFetched: begin
                    secondOperand <= 1'b0;
                    if (decoded.isLui) begin
                        memAddr <= regAddr(decoded.rdIdx);
                        writeEnable <= 1'b1;
                        strobe <= 1'b1;
                        state <= regStore;
                    end else if (decoded.isLoad || decoded.isAluOp) begin
                        memAddr <= regAddr(rs2First ? decoded.rs2Idx : decoded.rs1Idx);
                        strobe <= 1'b1;
                        state <= regFetch;
                    end else begin
                        // unsupported, skip it
                        state <= insnFetch;
                    end
                end
                regFetch: begin
                    if (shiftIdle && !aluPass && !wordDone) begin
                        memAddr <= memAddrNext;
                        strobe <= 1'b1;
                    end else if (wordReady && !startPass) begin
                        memAddr <= regAddr(decoded.rs1Idx);
                        strobe <= 1'b1;
                        secondOperand <= 1'b1;
                    end else if (startPass) begin
                        aluPass <= 1'b1;
                    end else if (passDone) begin
                        aluPass <= 1'b0;
                        strobe <= 1'b1;
                        if (decoded.isLoad) begin
                            // X holds rs1 + imm
                            memAddr <= xAddr;
                            state <= dataFetch;
                        end else begin
                            memAddr <= regAddr(decoded.rdIdx);
                            writeEnable <= 1'b1;
                            state <= regStore;
                        end
                    end
                end
                dataFetch: begin
                    if (shiftIdle) begin
                        strobe <= 1'b1;
                        if (wordDone) begin
                            memAddr <= regAddr(decoded.rdIdx);
                            writeEnable <= 1'b1;
                            state <= regStore;
                        end else begin
                            memAddr <= memAddrNext;
                        end
                    end
                end
                regStore: begin
                    if (writeDone && wordDone) begin
                        // fourth byte written
                        writeEnable <= 1'b0;
                        state <= insnFetch;
                    end else if (shiftIdle) begin
                        memAddr <= memAddrNext;
                        strobe <= 1'b1;
                    end
                end
                default: begin
                    state <= insnFetch;
                end
            endcase
        end
    end

    // request fields hold until the memory answers
    assert property (@(posedge cpuSignals) disable iff (!arstN)
        memReq.strobe && !memResp.ready |=>
            memReq.strobe && $stable(memReq.address) &&
            $stable(memReq.writeEnable) && $stable(memReq.dataWrite))
    else $error("bus request changed before ready");

endmodule

/* rtl/serialRiscvCore.sv */
`timescale 1ns/100ps
`include "serialCore_consts.svh"

module serialRiscvCore (
    input  logic cpuSignals,
    input  logic arstN,
    input  serialCorePkg::memRespT memResp,
    output serialCorePkg::memReqT memReq
);
    import serialCorePkg::*;

    logic [31:0] insn;
    decodedInsnT decoded;
    shiftCtrlT ctrl;
    aluOpT aluOp;
    logic aluClear;
    logic aluBit;
    logic xBit;
    logic yBit;
    logic byteDone;
    logic wordDone;
    logic [7:0] xLowByte;
    logic [`CORE_ADDR_WIDTH-1:0] xAddr;

    insnDecoder decoder_i (
        .insn    (insn),
        .decoded (decoded)
    );

    serialAlu alu_i (
        .cpuSignals (cpuSignals),
        .arstN      (arstN),
        .op         (aluOp),
        .clear      (aluClear),
        .xBit       (xBit),
        .yBit       (yBit),
        .aluBit     (aluBit)
    );

    // X and Y with the bit pacing counter
    operandShifter shifter_i (
        .cpuSignals (cpuSignals),
        .arstN      (arstN),
        .ctrl       (ctrl),
        .immediate  (decoded.immediate),
        .dataRead   (memResp.dataRead),
        .aluBit     (aluBit),
        .xBit       (xBit),
        .yBit       (yBit),
        .xLowByte   (xLowByte),
        .xAddr      (xAddr),
        .byteDone   (byteDone),
        .wordDone   (wordDone)
    );

    coreSequencer sequencer_i (
        .cpuSignals (cpuSignals),
        .arstN      (arstN),
        .memResp    (memResp),
        .decoded    (decoded),
        .byteDone   (byteDone),
        .wordDone   (wordDone),
        .xLowByte   (xLowByte),
        .xAddr      (xAddr),
        .memReq     (memReq),
        .insn       (insn),
        .ctrl       (ctrl),
        .aluOp      (aluOp),
        .aluClear   (aluClear)
    );

endmodule

/* verification/coreChecker.sv */
`timescale 1ns/100ps
`include "serialCore_consts.svh"

module coreChecker (
    input  logic cpuSignals,
    input  logic arstN,
    input  serialCorePkg::memReqT memReq,
    input  serialCorePkg::memRespT memResp,
    output int checkedCount,
    output int errorCount,
    output logic hung
);

    // architectural register file preset from the testbench at time 0
    logic [31:0] regModel [`CORE_REG_COUNT];

    task automatic presetRegister(input int idx, input logic [31:0] value);
        regModel[idx] = value;
    endtask

    // rd value from the RV32I rules of the kept instructions
    function automatic logic [31:0] referenceResult(input logic [31:0] insn,
            input logic [31:0] rs1Val, input logic [31:0] rs2Val,
            input logic [31:0] loadWord);
        logic [31:0] immI;
        logic [31:0] operand;
        immI = {{20{insn[31]}}, insn[31:20]};
        operand = (insn[6:0] == 7'h33) ? rs2Val : immI;
        case (insn[6:0])
            7'h37: referenceResult = {insn[31:12], 12'h000};
            7'h03: referenceResult = loadWord;
            7'h13, 7'h33: begin
                case (insn[14:12])
                    // bit 30 means subtract only in the register form
                    3'b000: referenceResult = (insn[6:0] == 7'h33 && insn[30]) ?
                        rs1Val - operand : rs1Val + operand;
                    3'b100: referenceResult = rs1Val ^ operand;
                    3'b110: referenceResult = rs1Val | operand;
                    3'b111: referenceResult = rs1Val & operand;
                    default: referenceResult = 'x;
                endcase
            end
            default: referenceResult = 'x;
        endcase
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        $display("[ERROR] %s got 0x%h expected 0x%h", name, got, expected);
        errorCount++;
    endtask

    // next completed transfer sampled mid-cycle where strobe and ready are stable
    task automatic nextTransfer(output logic [`CORE_ADDR_WIDTH-1:0] addr,
            output logic [7:0] data, output logic we, output int strobeLag);
        int cycles;
        logic seen;
        seen = 1'b0;
        addr = '0;
        data = '0;
        we = 1'b0;
        strobeLag = -1;
        for (cycles = 0; cycles < 200 && !seen && !hung; cycles++) begin
            @(negedge cpuSignals);
            if (memReq.strobe && strobeLag < 0) begin
                strobeLag = cycles + 1;
            end
            if (memReq.strobe && memResp.ready) begin
                seen = 1'b1;
                addr = memReq.address;
                we = memReq.writeEnable;
                data = memReq.writeEnable ? memReq.dataWrite : memResp.dataRead;
            end
        end
        if (!seen && !hung) begin
            $display("no bus transfer completed within 200 cycles");
            errorCount++;
            hung = 1'b1;
        end
    endtask

    initial begin
        logic [`CORE_ADDR_WIDTH-1:0] pc;
        logic [`CORE_ADDR_WIDTH-1:0] addr;
        logic [7:0] data;
        logic we;
        logic firstFetch;
        logic [31:0] insn;
        logic [31:0] rs1Val;
        logic [31:0] rs2Val;
        logic [31:0] loadAddr;
        logic [31:0] loadWord;
        logic [31:0] written;
        logic [31:0] expected;
        logic [31:0] expAddr;
        logic [6:0] opcode;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
        int strobeLag;
        int reads;
        int errorsBefore;
        int i;
        int cycles;
        checkedCount = 0;
        errorCount = 0;
        hung = 1'b0;
        firstFetch = 1'b1;
        pc = `CORE_RESET_PC;
        // bus stays idle while reset is held
        cycles = 0;
        do begin
            @(negedge cpuSignals);
            if (!arstN && (memReq.strobe !== 1'b0 || memReq.writeEnable !== 1'b0)) begin
                $display("bus request active during reset");
                errorCount++;
            end
            cycles++;
        end while (arstN !== 1'b1 && cycles < 20);
        if (arstN !== 1'b1) begin
            $display("reset still asserted after 20 cycles");
            errorCount++;
            hung = 1'b1;
        end
        while (!hung) begin
            errorsBefore = errorCount;
            // four fetch reads with the low byte first
            for (i = 0; i < 4; i++) begin
                nextTransfer(addr, data, we, strobeLag);
                if (!hung && we) begin
                    $display("fetch at 0x%h was a write", addr);
                    errorCount++;
                end else if (!hung && addr != pc + i) begin
                    reportMismatch("memReq.address (fetch)", addr, pc + i);
                end
                // next fetch starts within two cycles of the last write
                if (!hung && i == 0 && !firstFetch && strobeLag > 2) begin
                    $display("fetch strobe came %0d cycles after the write-back", strobeLag);
                    errorCount++;
                end
                insn[8*i +: 8] = data;
            end
            firstFetch = 1'b0;
            pc = pc + 4;
            opcode = insn[6:0];
            rd = insn[10:7];
            rs1 = insn[18:15];
            rs2 = insn[23:20];
            rs1Val = regModel[rs1];
            rs2Val = regModel[rs2];
            loadAddr = rs1Val + {{20{insn[31]}}, insn[31:20]};
            if (!hung && !(opcode inside {7'h37, 7'h13, 7'h33, 7'h03})) begin
                $display("fetched 0x%h, which is outside the kept set", insn);
                errorCount++;
                hung = 1'b1;
            end
            reads = (opcode == 7'h37) ? 0 : (opcode == 7'h13) ? 4 : 8;
            // operand reads followed by the LW data reads
            for (i = 0; i < reads && !hung; i++) begin
                nextTransfer(addr, data, we, strobeLag);
                if (i < 4) begin
                    // register form reads rs2 first
                    expAddr = (opcode == 7'h33 ? {rs2, 2'b00} : {rs1, 2'b00}) + i;
                end else if (opcode == 7'h03) begin
                    expAddr = loadAddr + i - 4;
                end else begin
                    expAddr = {rs1, 2'b00} + i - 4;
                end
                if (!hung && we) begin
                    $display("operand read at 0x%h was a write", addr);
                    errorCount++;
                end else if (!hung && addr != expAddr[`CORE_ADDR_WIDTH-1:0]) begin
                    reportMismatch("memReq.address (read)", addr, expAddr);
                end
                loadWord[8*(i%4) +: 8] = data;
            end
            // ascending write-back to 4*rd
            for (i = 0; i < 4 && !hung; i++) begin
                nextTransfer(addr, data, we, strobeLag);
                if (!hung && !we) begin
                    $display("expected a write-back to x%0d, got a read at 0x%h", rd, addr);
                    errorCount++;
                end else if (!hung && addr != {rd, 2'b00} + i) begin
                    reportMismatch("memReq.address (write-back)", addr, {rd, 2'b00} + i);
                end
                written[8*i +: 8] = data;
            end
            if (!hung) begin
                expected = referenceResult(insn, rs1Val, rs2Val, loadWord);
                if (written !== expected) begin
                    reportMismatch($sformatf("memReq.dataWrite word of x%0d", rd),
                        written, expected);
                end
                regModel[rd] = expected;
                checkedCount++;
                $display("test %0d pc 0x%h insn 0x%h x%0d = 0x%h: %s", checkedCount,
                    pc - 4, insn, rd, written, errorCount == errorsBefore ? "ok" : "mismatch");
            end
        end
    end

endmodule

/* verification/coreTb.sv */
`timescale 1ns/100ps
`include "serialCore_consts.svh"

module coreTb;
    import serialCorePkg::*;

    localparam int RandomCount = 40;
    // run bound with ample room for 61 instructions of a few hundred cycles
    localparam int CycleLimit = 40000;

    logic cpuSignals;
    logic arstN;
    memReqT memReq;
    memRespT memResp;
    int checkedCount;
    int errorCount;
    logic hung;
    int seed;
    logic [7:0] mem [0:65535];
    logic [31:0] progWords [$];

    serialRiscvCore dut_i (
        .cpuSignals (cpuSignals),
        .arstN      (arstN),
        .memResp    (memResp),
        .memReq     (memReq)
    );

    coreChecker checker_i (
        .cpuSignals   (cpuSignals),
        .arstN        (arstN),
        .memReq       (memReq),
        .memResp      (memResp),
        .checkedCount (checkedCount),
        .errorCount   (errorCount),
        .hung         (hung)
    );

    initial begin
        cpuSignals = 1'b0;
        forever begin
            #50;
            cpuSignals = ~cpuSignals;
        end
    end

    function automatic logic [7:0] fillByte(input logic [15:0] a);
        fillByte = a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h5a;
    endfunction

    function automatic logic [31:0] immInsn(input logic [6:0] opcode, input logic [3:0] rd,
            input logic [2:0] f3, input logic [3:0] rs1, input int imm);
        immInsn = {imm[11:0], 1'b0, rs1, f3, 1'b0, rd, opcode};
    endfunction

    function automatic logic [31:0] regInsn(input logic sub, input logic [3:0] rd,
            input logic [2:0] f3, input logic [3:0] rs1, input logic [3:0] rs2);
        regInsn = {1'b0, sub, 5'b0, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'h33};
    endfunction

    function automatic logic [31:0] luiInsn(input logic [3:0] rd, input int upper);
        luiInsn = {upper[19:0], 1'b0, rd, 7'h37};
    endfunction

    // rd stays in 1..14 so x15 keeps the load base
    function automatic logic [31:0] randomInsn();
        int kind;
        int pick;
        int r;
        logic [3:0] rd;
        logic [2:0] f3;
        kind = {$random(seed)} % 4;
        pick = {$random(seed)} % 14;
        rd = pick[3:0] + 4'd1;
        // pick 0..3 maps to funct3 000, 100, 110, 111
        pick = {$random(seed)} % 4;
        f3 = (pick == 0) ? 3'b000 : {1'b1, pick[1], pick[1] & pick[0]};
        r = $random(seed);
        case (kind)
            0: randomInsn = luiInsn(rd, $random(seed));
            1: randomInsn = immInsn(7'h13, rd, f3, r[3:0], $random(seed));
            2: randomInsn = regInsn(f3 == 3'b000 && r[8], rd, f3, r[3:0], r[7:4]);
            default: randomInsn = immInsn(7'h03, rd, 3'b010, 4'd15,
                ({$random(seed)} % 512) * 4 - 1024);
        endcase
    endfunction

    task automatic buildProgram();
        int k;
        progWords.push_back(luiInsn(1, 20'habcde));
        progWords.push_back(luiInsn(2, 20'h80001));
        progWords.push_back(immInsn(7'h13, 3, 3'b000, 4, -5));
        progWords.push_back(immInsn(7'h13, 5, 3'b000, 6, 2047));
        progWords.push_back(immInsn(7'h13, 7, 3'b100, 8, -1));
        progWords.push_back(immInsn(7'h13, 9, 3'b100, 10, 'h123));
        progWords.push_back(immInsn(7'h13, 11, 3'b110, 12, -2048));
        progWords.push_back(immInsn(7'h13, 13, 3'b110, 1, 'h0f0));
        progWords.push_back(immInsn(7'h13, 14, 3'b111, 2, -16));
        progWords.push_back(immInsn(7'h13, 3, 3'b111, 4, 'h3ff));
        progWords.push_back(regInsn(1'b0, 5, 3'b000, 1, 2));
        progWords.push_back(regInsn(1'b1, 6, 3'b000, 1, 2));
        progWords.push_back(regInsn(1'b1, 7, 3'b000, 2, 1));
        progWords.push_back(regInsn(1'b0, 8, 3'b100, 3, 4));
        progWords.push_back(regInsn(1'b0, 9, 3'b110, 5, 6));
        progWords.push_back(regInsn(1'b0, 10, 3'b111, 7, 8));
        progWords.push_back(regInsn(1'b0, 11, 3'b000, 11, 11));
        // loads around the data words at 0x1000
        progWords.push_back(immInsn(7'h03, 12, 3'b010, 15, 0));
        progWords.push_back(immInsn(7'h03, 13, 3'b010, 15, 8));
        progWords.push_back(immInsn(7'h03, 14, 3'b010, 15, 2044));
        progWords.push_back(immInsn(7'h03, 1, 3'b010, 15, -4));
        for (k = 0; k < RandomCount; k++) begin
            progWords.push_back(randomInsn());
        end
    endtask

    // byte memory raising ready 1 to 4 cycles after strobe
    initial begin
        int waitCnt;
        logic busy;
        memResp = '0;
        busy = 1'b0;
        waitCnt = 0;
        forever begin
            @(posedge cpuSignals);
            #10;
            if (memResp.ready) begin
                memResp.ready = 1'b0;
                busy = 1'b0;
            end else if (memReq.strobe) begin
                if (!busy) begin
                    busy = 1'b1;
                    waitCnt = {$random(seed)} % 4;
                end
                if (waitCnt == 0) begin
                    if (memReq.writeEnable) begin
                        mem[memReq.address] = memReq.dataWrite;
                    end else begin
                        memResp.dataRead = mem[memReq.address];
                    end
                    memResp.ready = 1'b1;
                end else begin
                    waitCnt--;
                end
            end
        end
    end

    initial begin
        int i;
        int b;
        int cycles;
        logic [31:0] value;
        arstN = 1'b0;
        seed = 88083;
        // data words at 0x1000 come from this fill
        for (i = 0; i < 65536; i++) begin
            mem[i] = fillByte(i[15:0]);
        end
        // register file at word 0 with the load base in x15
        for (i = 0; i < `CORE_REG_COUNT; i++) begin
            value = (i == 0) ? 32'h0 : (i == 15) ? 32'h0000_1000 : $random(seed);
            for (b = 0; b < 4; b++) begin
                mem[4*i + b] = value[8*b +: 8];
            end
            checker_i.presetRegister(i, value);
        end
        buildProgram();
        for (i = 0; i < progWords.size(); i++) begin
            for (b = 0; b < 4; b++) begin
                mem[`CORE_RESET_PC + 4*i + b] = progWords[i][8*b +: 8];
            end
        end
        repeat (4) begin
            @(posedge cpuSignals);
        end
        #10;
        arstN = 1'b1;
        for (cycles = 0; cycles < CycleLimit && checkedCount < progWords.size() && !hung;
                cycles++) begin
            @(negedge cpuSignals);
        end
        if (checkedCount != progWords.size()) begin
            $display("run stopped after %0d cycles with instructions left unchecked", cycles);
        end
        $display("checked %0d of %0d instructions, %0d errors", checkedCount,
            progWords.size(), errorCount);
        if (checkedCount == progWords.size() && errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/serialCorePkg.sv
rtl/insnDecoder.sv
rtl/serialAlu.sv
rtl/operandShifter.sv
rtl/coreSequencer.sv
rtl/serialRiscvCore.sv
verification/coreChecker.sv
verification/coreTb.sv

/* Bender.yml */
package:
  name: serial_riscv_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/serialCorePkg.sv
      - rtl/insnDecoder.sv
      - rtl/serialAlu.sv
      - rtl/operandShifter.sv
      - rtl/coreSequencer.sv
      - rtl/serialRiscvCore.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/coreChecker.sv
      - verification/coreTb.sv
